//--- hdl/age_matrix.sv
module age_matrix (
    input  logic                   clk,
    input  logic                   reset,
    iq_alloc_if.sink               alloc,
    input  iq_cfg_pkg::slot_mask_t rdy,
    output iq_cfg_pkg::slot_mask_t sel
);
    import iq_cfg_pkg::*;

    // older[i][j] set means entry i came before entry j.
    logic [IQ_DEPTH-1:0][IQ_DEPTH-1:0] older;

    always_ff @(posedge clk) begin
        if (reset) begin
            older <= '0;
        end else if (alloc.fire) begin
            for (int i = 0; i < IQ_DEPTH; i++) begin
                for (int j = 0; j < IQ_DEPTH; j++) begin
                    // The new row clears, every other row gains the new column.
                    older[i][j] <= alloc.slot[i] ? 1'b0 : (older[i][j] | alloc.slot[j]);
                end
            end
        end
    end

    // An entry wins when no other ready entry is older than it.
    always_comb begin
        for (int i = 0; i < IQ_DEPTH; i++) begin
            sel[i] = rdy[i];
            for (int j = 0; j < IQ_DEPTH; j++) begin
                if (j != i) begin
                    sel[i] = sel[i] & (~rdy[j] | older[i][j]);
                end
            end
        end
    end

endmodule

//--- hdl/entry_store.sv
module entry_store (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   alloc_valid,
    input  iq_cfg_pkg::tag_t       alloc_tag,
    input  iq_cfg_pkg::wait_t      alloc_wait,
    input  logic                   accept,
    input  logic                   flush_now,
    input  logic                   issue_en,
    input  iq_cfg_pkg::slot_mask_t sel,
    iq_alloc_if.src                alloc,
    output iq_cfg_pkg::slot_mask_t valid,
    output logic                   slot_full,
    output logic                   alloc_ready,
    output logic                   issue_fire,
    output logic                   issue_valid,
    output iq_cfg_pkg::tag_t       issue_tag
);
    import iq_cfg_pkg::*;

    tag_t       tags [IQ_DEPTH];
    slot_mask_t free;

    assign free      = ~valid;
    assign slot_full = &valid;

    // Lowest free slot, one-hot.
    assign alloc.slot     = free & (~free + slot_mask_t'(1));
    assign alloc.fire     = alloc_valid && accept;
    assign alloc.tag      = alloc_tag;
    assign alloc.wait_cnt = alloc_wait;
    assign alloc_ready    = accept;

    assign issue_valid = issue_en && !flush_now && (sel != '0);
    assign issue_fire  = issue_valid;

    // Select is one-hot, so an OR of the gated tags is the read-out.
    always_comb begin
        issue_tag = '0;
        for (int i = 0; i < IQ_DEPTH; i++) begin
            if (sel[i]) begin
                issue_tag = issue_tag | tags[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush_now) begin
            valid <= '0;
        end else begin
            valid <= (valid & ~(issue_fire ? sel : '0))
                   | (alloc.fire ? alloc.slot : '0);
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < IQ_DEPTH; i++) begin
            if (alloc.fire && alloc.slot[i]) begin
                tags[i] <= alloc.tag;
            end
        end
    end

endmodule

//--- hdl/iq_alloc_if.sv
interface iq_alloc_if;
    import iq_cfg_pkg::*;

    logic       fire;      // One-cycle allocation strobe.
    slot_mask_t slot;      // One-hot target slot.
    tag_t       tag;
    wait_t      wait_cnt;  // Operand wait, named apart from the wait keyword.

    // Entry store produces the allocation.
    modport src (
        output fire, slot, tag, wait_cnt
    );

    // Timer and age matrix follow it.
    modport sink (
        input fire, slot, tag, wait_cnt
    );

endinterface

//--- hdl/iq_cfg_pkg.sv
package iq_cfg_pkg;

    // Queue geometry.
    localparam int IQ_DEPTH = 8;
    localparam int TAG_W    = 6;   // Instruction tag width.
    localparam int WAIT_W   = 3;   // Operand wait count width.
    localparam int CNT_W    = 4;   // Holds 0 to IQ_DEPTH.

    // Instruction tag.
    typedef logic [TAG_W-1:0] tag_t;

    // Cycles until the operands arrive.
    typedef logic [WAIT_W-1:0] wait_t;

    // One bit per entry, for one-hot slots, valid, ready and select.
    typedef logic [IQ_DEPTH-1:0] slot_mask_t;

    // Number of valid entries.
    typedef logic [CNT_W-1:0] occ_t;

endpackage

//--- hdl/iq_ctrl_fsm.sv
module iq_ctrl_fsm (
    input  logic              clk,
    input  logic              reset,
    input  logic              alloc_fire,
    input  logic              issue_fire,
    input  logic              slot_full,
    input  logic              flush,
    output logic              accept,
    output logic              flush_now,
    output iq_cfg_pkg::occ_t  occupancy
);
    import iq_cfg_pkg::*;
    import iq_ctrl_pkg::*;

    iq_state_t state;
    iq_state_t state_next;
    occ_t      cnt_next;

    assign flush_now = (state == Q_FLUSH);

    // Slot_full guards against a count that runs ahead of the valid bits.
    assign accept = (state == Q_EMPTY || state == Q_PARTIAL) && !slot_full;

    always_comb begin
        if (flush_now) begin
            cnt_next = '0; // Entries are wiped this edge.
        end else begin
            cnt_next = occupancy + occ_t'(alloc_fire) - occ_t'(issue_fire);
        end

        if (flush) begin
            state_next = Q_FLUSH;
        end else if (cnt_next == occ_t'(IQ_DEPTH)) begin
            state_next = Q_FULL;
        end else if (cnt_next == '0) begin
            state_next = Q_EMPTY;
        end else begin
            state_next = Q_PARTIAL;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= Q_EMPTY;
            occupancy <= '0;
        end else begin
            state     <= state_next;
            occupancy <= cnt_next;
        end
    end

endmodule

//--- hdl/iq_ctrl_pkg.sv
package iq_ctrl_pkg;

    // Occupancy control states.
    typedef enum logic [1:0] {
        Q_EMPTY   = 2'd0,
        Q_PARTIAL = 2'd1,
        Q_FULL    = 2'd2,
        Q_FLUSH   = 2'd3
    } iq_state_t;

endpackage

//--- hdl/issue_queue_top.sv
module issue_queue_top (
    input  logic              clk,
    input  logic              reset,
    input  logic              alloc_valid,
    input  iq_cfg_pkg::tag_t  alloc_tag,
    input  iq_cfg_pkg::wait_t alloc_wait,
    input  logic              issue_en,
    input  logic              flush,
    output logic              alloc_ready,
    output logic              issue_valid,
    output iq_cfg_pkg::tag_t  issue_tag,
    output iq_cfg_pkg::occ_t  occupancy
);
    import iq_cfg_pkg::*;

    iq_alloc_if alloc_bus ();

    slot_mask_t valid;
    slot_mask_t rdy;
    slot_mask_t sel;    // Oldest ready entry.
    logic       slot_full;
    logic       issue_fire;
    logic       accept;
    logic       flush_now;

    entry_store u_entry_store (
        .clk         (clk),
        .reset       (reset),
        .alloc_valid (alloc_valid),
        .alloc_tag   (alloc_tag),
        .alloc_wait  (alloc_wait),
        .accept      (accept),
        .flush_now   (flush_now),
        .issue_en    (issue_en),
        .sel         (sel),
        .alloc       (alloc_bus.src),
        .valid       (valid),
        .slot_full   (slot_full),
        .alloc_ready (alloc_ready),
        .issue_fire  (issue_fire),
        .issue_valid (issue_valid),
        .issue_tag   (issue_tag)
    );

    operand_timer u_operand_timer (
        .clk   (clk),
        .reset (reset),
        .alloc (alloc_bus.sink),
        .valid (valid),
        .rdy   (rdy)
    );

    age_matrix u_age_matrix (
        .clk   (clk),
        .reset (reset),
        .alloc (alloc_bus.sink),
        .rdy   (rdy),
        .sel   (sel)
    );

    iq_ctrl_fsm u_ctrl_fsm (
        .clk        (clk),
        .reset      (reset),
        .alloc_fire (alloc_bus.fire),
        .issue_fire (issue_fire),
        .slot_full  (slot_full),
        .flush      (flush),
        .accept     (accept),
        .flush_now  (flush_now),
        .occupancy  (occupancy)
    );

endmodule

//--- hdl/operand_timer.sv
module operand_timer (
    input  logic                   clk,
    input  logic                   reset,
    iq_alloc_if.sink               alloc,
    input  iq_cfg_pkg::slot_mask_t valid,
    output iq_cfg_pkg::slot_mask_t rdy
);
    import iq_cfg_pkg::*;

    wait_t cnt [IQ_DEPTH];

    // A counter loads on allocation and then runs down to zero.
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < IQ_DEPTH; i++) begin
                cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < IQ_DEPTH; i++) begin
                if (alloc.fire && alloc.slot[i]) begin
                    cnt[i] <= alloc.wait_cnt;
                end else if (valid[i] && cnt[i] != '0) begin
                    cnt[i] <= cnt[i] - 1'b1;
                end
            end
        end
    end

    // Ready once the count has drained.
    always_comb begin
        for (int i = 0; i < IQ_DEPTH; i++) begin
            rdy[i] = valid[i] && (cnt[i] == '0);
        end
    end

endmodule

//--- issue_queue.f
hdl/iq_cfg_pkg.sv
hdl/iq_ctrl_pkg.sv
hdl/iq_alloc_if.sv
hdl/iq_ctrl_fsm.sv
hdl/operand_timer.sv
hdl/entry_store.sv
hdl/age_matrix.sv
hdl/issue_queue_top.sv
verif/iq_assert.sv
verif/iq_checker.sv
verif/tb_issue_queue.sv

//--- run_sim.sh
#!/bin/sh
# Builds the issue queue testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_issue_queue \
    -f issue_queue.f \
    -Mdir obj_dir -o sim_issue_queue
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_issue_queue > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TESTBENCH FAILED" sim.log; then
    exit 1
fi
exit 0

//--- verif/iq_assert.sv
module iq_assert (
    input logic                   clk,
    input logic                   reset,
    input iq_cfg_pkg::slot_mask_t sel,
    input iq_cfg_pkg::occ_t       occupancy,
    input logic                   alloc_ready,
    input logic                   issue_valid,
    input logic                   flush
);
    import iq_cfg_pkg::*;

    int fail_count = 0;  // Assertion failures so far.

    // Age select picks at most one entry.
    a_sel_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(sel))
        else begin
            $error("Age select has more than one entry set");
            fail_count++;
        end

    a_full_stall: assert property (@(posedge clk) disable iff (reset)
        (occupancy == occ_t'(IQ_DEPTH)) |-> !alloc_ready)
        else begin
            $error("Allocation offered while the queue is full");
            fail_count++;
        end

    // The flush cycle itself never issues.
    a_flush_quiet: assert property (@(posedge clk) disable iff (reset)
        flush |=> !issue_valid)
        else begin
            $error("Issue seen in the cycle after a flush request");
            fail_count++;
        end

endmodule

bind issue_queue_top iq_assert u_iq_assert (
    .clk         (clk),
    .reset       (reset),
    .sel         (sel),
    .occupancy   (occupancy),
    .alloc_ready (alloc_ready),
    .issue_valid (issue_valid),
    .flush       (flush)
);

//--- verif/iq_checker.sv
module iq_checker (
    input logic              clk,
    input logic              reset,
    input logic              alloc_valid,
    input iq_cfg_pkg::tag_t  alloc_tag,
    input iq_cfg_pkg::wait_t alloc_wait,
    input logic              issue_en,
    input logic              flush,
    input logic              alloc_ready,
    input logic              issue_valid,
    input iq_cfg_pkg::tag_t  issue_tag,
    input iq_cfg_pkg::occ_t  occupancy
);
    import iq_cfg_pkg::*;

    tag_t  q_tag [$];     // Entries, oldest first.
    int    q_ready [$];   // First cycle each entry is ready.
    logic  in_flush;
    int    cyc;
    string cur_test = "idle";
    int    test_errs = 0;
    int    err_total = 0;
    int    tests_passed = 0;
    int    tests_failed = 0;

    // Index of the oldest entry whose wait is over, or -1.
    function automatic int oldest_ready();
        for (int i = 0; i < q_tag.size(); i++) begin
            if (q_ready[i] <= cyc) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic check_value(input string what, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            $display("Fail %s: %s expected %0h, actual %0h (cycle %0d)",
                     cur_test, what, exp, act, cyc);
            test_errs++;
            err_total++;
        end
    endtask

    task automatic step_model();
        int   pick;
        logic exp_ready;
        logic exp_valid;
        if (reset) begin
            q_tag.delete();
            q_ready.delete();
            in_flush = 1'b0;
            cyc      = 0;
        end else begin
            pick      = oldest_ready();
            exp_ready = !in_flush && (q_tag.size() < IQ_DEPTH);
            exp_valid = issue_en && !in_flush && (pick >= 0);
            check_value("alloc_ready", 8'(exp_ready), 8'(alloc_ready));
            check_value("issue_valid", 8'(exp_valid), 8'(issue_valid));
            check_value("occupancy", 8'(q_tag.size()), 8'(occupancy));
            if (exp_valid) begin
                check_value("issue_tag", 8'(q_tag[pick]), 8'(issue_tag));
            end

            // What the coming edge does.
            if (in_flush) begin
                q_tag.delete();
                q_ready.delete();
            end else begin
                if (exp_valid) begin
                    q_tag.delete(pick);
                    q_ready.delete(pick);
                end
                if (alloc_valid && exp_ready) begin
                    q_tag.push_back(alloc_tag);
                    q_ready.push_back(cyc + 1 + int'(alloc_wait)); // Ready after wait edges.
                end
            end
            in_flush = flush;
            cyc++;
        end
    endtask

    task automatic begin_test(input string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        if (test_errs == 0) begin
            $display("Test %s: passed", cur_test);
            tests_passed++;
        end else begin
            $display("Test %s: failed with %0d mismatches", cur_test, test_errs);
            tests_failed++;
        end
        cur_test = "idle";
    endtask

    // Outputs settle well before the falling edge.
    always @(negedge clk) begin
        step_model();
    end

endmodule

//--- verif/tb_issue_queue.sv
module tb_issue_queue;
    import iq_cfg_pkg::*;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 4;
    localparam int OOO_COUNT    = 24;
    localparam int MIX_CYCLES   = 400;
    localparam int WAIT_MAX     = (1 << WAIT_W) - 1;
    localparam int TEST_CYCLES  = RESET_CYCLES + 4 + 3 * IQ_DEPTH + OOO_COUNT * (WAIT_MAX + 3)
                                + 8 * IQ_DEPTH + MIX_CYCLES + IQ_DEPTH * (WAIT_MAX + 2);
    localparam int WATCHDOG_CYCLES = 2 * TEST_CYCLES;

    logic  clk;
    logic  reset;
    logic  alloc_valid;
    tag_t  alloc_tag;
    wait_t alloc_wait;
    logic  issue_en;
    logic  flush;
    logic  alloc_ready;
    logic  issue_valid;
    tag_t  issue_tag;
    occ_t  occupancy;
    int    seed = 23;
    tag_t  next_tag;

    issue_queue_top dut (
        .clk         (clk),
        .reset       (reset),
        .alloc_valid (alloc_valid),
        .alloc_tag   (alloc_tag),
        .alloc_wait  (alloc_wait),
        .issue_en    (issue_en),
        .flush       (flush),
        .alloc_ready (alloc_ready),
        .issue_valid (issue_valid),
        .issue_tag   (issue_tag),
        .occupancy   (occupancy)
    );

    iq_checker chk (
        .clk         (clk),
        .reset       (reset),
        .alloc_valid (alloc_valid),
        .alloc_tag   (alloc_tag),
        .alloc_wait  (alloc_wait),
        .issue_en    (issue_en),
        .flush       (flush),
        .alloc_ready (alloc_ready),
        .issue_valid (issue_valid),
        .issue_tag   (issue_tag),
        .occupancy   (occupancy)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Inputs change just after the rising edge.
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // Holds the offer until the queue takes it.
    task automatic offer(input tag_t tag, input wait_t w);
        logic took;
        alloc_valid = 1'b1;
        alloc_tag   = tag;
        alloc_wait  = w;
        do begin
            took = alloc_ready;
            next_cycle();
        end while (!took);
        alloc_valid = 1'b0;
    endtask

    task automatic fill_until_full(input wait_t w);
        while (alloc_ready) begin
            offer(next_tag, w);
            next_tag++;
        end
    endtask

    task automatic drain();
        issue_en = 1'b1;
        while (occupancy != '0) begin
            next_cycle();
        end
    endtask

    initial begin : stimulus
        logic took;
        clk         = 1'b0;
        reset       = 1'b1;
        alloc_valid = 1'b0;
        alloc_tag   = '0;
        alloc_wait  = '0;
        issue_en    = 1'b0;
        flush       = 1'b0;
        next_tag    = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;

        chk.begin_test("reset_state");
        repeat (3) next_cycle();
        chk.end_test();

        chk.begin_test("in_order_drain");
        fill_until_full(wait_t'(0));  // All ready, none issued yet.
        drain();
        chk.end_test();

        chk.begin_test("out_of_order_ready");
        issue_en = 1'b1;
        for (int k = 0; k < OOO_COUNT; k++) begin
            offer(next_tag, wait_t'($random(seed)));
            next_tag++;
            if (($random(seed) & 1) != 0) begin
                next_cycle();
            end
        end
        drain();
        chk.end_test();

        chk.begin_test("full_backpressure");
        issue_en = 1'b0;
        fill_until_full(wait_t'(0));
        alloc_valid = 1'b1;
        alloc_tag   = next_tag;
        alloc_wait  = '0;
        repeat (3) next_cycle();      // Offer held against a full queue.
        issue_en = 1'b1;
        next_cycle();
        issue_en = 1'b0;
        offer(next_tag, wait_t'(0));  // Taken once the slot frees.
        next_tag++;
        drain();
        chk.end_test();

        chk.begin_test("flush");
        issue_en = 1'b0;
        repeat (5) begin
            offer(next_tag, wait_t'($random(seed)));
            next_tag++;
        end
        issue_en = 1'b1;
        flush    = 1'b1;
        next_cycle();
        flush = 1'b0;
        while (occupancy != '0) begin
            next_cycle();
        end
        repeat (4) next_cycle();
        chk.end_test();

        chk.begin_test("random_mix");
        took = 1'b1;
        for (int c = 0; c < MIX_CYCLES; c++) begin
            if (!alloc_valid || took) begin
                alloc_valid = ($random(seed) & 1) != 0;
                alloc_tag   = tag_t'($random(seed));
                alloc_wait  = wait_t'($random(seed));
            end
            issue_en = ($random(seed) & 3) != 0;
            flush    = ($random(seed) & 63) == 0;   // Rare flush.
            took     = alloc_valid && alloc_ready;
            next_cycle();
        end
        alloc_valid = 1'b0;
        flush       = 1'b0;
        drain();
        chk.end_test();

        $display("Tests passed: %0d, tests failed: %0d, mismatches: %0d, assertion errors: %0d",
                 chk.tests_passed, chk.tests_failed, chk.err_total,
                 dut.u_iq_assert.fail_count);
        if (chk.tests_failed == 0 && chk.err_total == 0
                && dut.u_iq_assert.fail_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, a test stalled waiting on the DUT",
                 WATCHDOG_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule
